/* exe_stage.sv */
// alu and branch resolution
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input  logic [63:0]          pc,
	input  logic [31:0]          inst,
	input  rv_core_pkg::dec_t    dec,
	input  logic [63:0]          rs1_data,
	input  logic [63:0]          rs2_data,
	output rv_core_pkg::retire_t rec
);
	import rv_core_pkg::*;

	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] jalr_sum;
	logic [XLEN-1:0] next_pc;
	logic            cmp;
	logic            br_taken;

	function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	assign op1 = dec.op1;
	assign op2 = dec.op2;

	always_comb begin
		alu_res = '0;
		cmp = 1'b0;
		case (dec.alu_op)
			ALU_ADD: alu_res = op1 + op2;
			ALU_SUB: alu_res = op1 - op2;
			ALU_SLL: alu_res = op1 << op2[5:0];
			ALU_SLT: alu_res = {63'b0, $signed(op1) < $signed(op2)};
			ALU_SLTU: alu_res = {63'b0, op1 < op2};
			ALU_XOR: alu_res = op1 ^ op2;
			ALU_SRL: alu_res = op1 >> op2[5:0];
			ALU_SRA: alu_res = $signed(op1) >>> op2[5:0];
			ALU_OR: alu_res = op1 | op2;
			ALU_AND: alu_res = op1 & op2;
			ALU_LUI: alu_res = op2;
			ALU_ADDW: alu_res = sext_w(op1[31:0] + op2[31:0]);
			ALU_SUBW: alu_res = sext_w(op1[31:0] - op2[31:0]);
			ALU_SLLW: alu_res = sext_w(op1[31:0] << op2[4:0]);
			ALU_SRLW: alu_res = sext_w(op1[31:0] >> op2[4:0]);
			ALU_SRAW: alu_res = sext_w($signed(op1[31:0]) >>> op2[4:0]);
			ALU_BEQ: cmp = (op1 == op2);
			ALU_BNE: cmp = (op1 != op2);
			ALU_BLT: cmp = ($signed(op1) < $signed(op2));
			ALU_BGE: cmp = ($signed(op1) >= $signed(op2));
			ALU_BLTU: cmp = (op1 < op2);
			ALU_BGEU: cmp = (op1 >= op2);
			default: alu_res = '0;
		endcase
	end

	assign br_taken = dec.branch && cmp;
	assign jalr_sum = rs1_data + dec.j_offset;

	always_comb begin
		if (dec.jump[1])
			next_pc = pc + dec.j_offset;
		else if (dec.jump[0])
			next_pc = {jalr_sum[XLEN-1:1], 1'b0};
		else if (br_taken)
			next_pc = pc + dec.b_offset;
		else
			next_pc = pc + 64'd4;
	end

	always_comb begin
		rec.pc = pc;
		rec.inst = inst;
		rec.rd_wr = dec.rd_w_ena && !dec.mem_to_reg;   // loads retire without a write
		rec.rd = dec.rd_w_addr;
		rec.result = (dec.branch || dec.mem_w_ena) ? '0 : alu_res;
		rec.taken = br_taken || (dec.jump != 2'b00);
		rec.next_pc = next_pc;
		rec.mem_r_ena = dec.mem_r_ena;
		rec.mem_w_ena = dec.mem_w_ena;
		rec.mem_addr = alu_res;
		rec.store_data = rs2_data;
		rec.byte_enable = dec.byte_enable;
		rec.mem_ext_un = dec.mem_ext_un;
	end

endmodule

`default_nettype wire

/* id_stage.sv */
// rv64i instruction decoder
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic [31:0]      inst,
	input  logic [63:0]      pc,
	input  logic [63:0]      rs1_data,
	input  logic [63:0]      rs2_data,
	output rv_core_pkg::dec_t dec
);
	import rv_core_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec = '0;   // unknown opcode leaves everything off
		case (opcode)
			OPC_OP_IMM, OPC_OP_IMM32: begin
				dec.rs1_r_ena = 1'b1;
				dec.rd_w_ena = 1'b1;
				dec.op1 = rs1_data;
				dec.op2 = imm_i;
				case (funct3)
					F3_ADD_SUB: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_ADD : ALU_ADDW;
					F3_SLL: begin
						dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_SLL : ALU_SLLW;
						dec.op2 = {58'b0, inst[25:20]};
					end
					F3_SR: begin
						if (opcode == OPC_OP_IMM)
							dec.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
						else
							dec.alu_op = inst[30] ? ALU_SRAW : ALU_SRLW;
						dec.op2 = {58'b0, inst[25:20]};
					end
					F3_SLT: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_SLT : ALU_ZERO;
					F3_SLTU: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_SLTU : ALU_ZERO;
					F3_XOR: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_XOR : ALU_ZERO;
					F3_OR: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_OR : ALU_ZERO;
					F3_AND: dec.alu_op = (opcode == OPC_OP_IMM) ? ALU_AND : ALU_ZERO;
					default: dec.alu_op = ALU_ZERO;
				endcase
			end
			OPC_OP, OPC_OP32: begin
				dec.rs1_r_ena = 1'b1;
				dec.rs2_r_ena = 1'b1;
				dec.rd_w_ena = 1'b1;
				dec.op1 = rs1_data;
				dec.op2 = rs2_data;
				case (funct3)
					F3_ADD_SUB: begin
						if (opcode == OPC_OP)
							dec.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
						else
							dec.alu_op = inst[30] ? ALU_SUBW : ALU_ADDW;
					end
					F3_SLL: dec.alu_op = (opcode == OPC_OP) ? ALU_SLL : ALU_SLLW;
					F3_SR: begin
						if (opcode == OPC_OP)
							dec.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
						else
							dec.alu_op = inst[30] ? ALU_SRAW : ALU_SRLW;
					end
					F3_SLT: dec.alu_op = (opcode == OPC_OP) ? ALU_SLT : ALU_ZERO;
					F3_SLTU: dec.alu_op = (opcode == OPC_OP) ? ALU_SLTU : ALU_ZERO;
					F3_XOR: dec.alu_op = (opcode == OPC_OP) ? ALU_XOR : ALU_ZERO;
					F3_OR: dec.alu_op = (opcode == OPC_OP) ? ALU_OR : ALU_ZERO;
					F3_AND: dec.alu_op = (opcode == OPC_OP) ? ALU_AND : ALU_ZERO;
					default: dec.alu_op = ALU_ZERO;
				endcase
			end
			OPC_LUI: begin
				dec.rd_w_ena = 1'b1;
				dec.op2 = imm_u;
				dec.alu_op = ALU_LUI;
			end
			OPC_AUIPC: begin
				dec.rd_w_ena = 1'b1;
				dec.op1 = pc;
				dec.op2 = imm_u;
				dec.alu_op = ALU_ADD;
			end
			OPC_BRANCH: begin
				dec.rs1_r_ena = 1'b1;
				dec.rs2_r_ena = 1'b1;
				dec.op1 = rs1_data;
				dec.op2 = rs2_data;
				dec.branch = 1'b1;
				dec.b_offset = imm_b;
				case (funct3)
					F3_BEQ: dec.alu_op = ALU_BEQ;
					F3_BNE: dec.alu_op = ALU_BNE;
					F3_BLT: dec.alu_op = ALU_BLT;
					F3_BGE: dec.alu_op = ALU_BGE;
					F3_BLTU: dec.alu_op = ALU_BLTU;
					F3_BGEU: dec.alu_op = ALU_BGEU;
					default: dec.alu_op = ALU_ZERO;
				endcase
			end
			OPC_JAL, OPC_JALR: begin
				dec.rs1_r_ena = (opcode == OPC_JALR);   // jalr target from rs1
				dec.rd_w_ena = 1'b1;
				dec.op1 = pc;   // link value
				dec.op2 = 64'd4;
				dec.alu_op = ALU_ADD;
				dec.jump = (opcode == OPC_JAL) ? 2'b10 : 2'b01;
				dec.j_offset = (opcode == OPC_JAL) ? imm_j : imm_i;
			end
			OPC_LOAD: begin
				dec.rs1_r_ena = 1'b1;
				dec.rd_w_ena = 1'b1;
				dec.op1 = rs1_data;
				dec.op2 = imm_i;
				dec.alu_op = ALU_ADD;
				dec.mem_r_ena = 1'b1;
				dec.mem_to_reg = 1'b1;
				dec.mem_ext_un = (funct3 == F3_LBU) || (funct3 == F3_LHU) || (funct3 == F3_LWU);
				case (funct3)
					F3_LB, F3_LBU: dec.byte_enable = 8'h01;
					F3_LH, F3_LHU: dec.byte_enable = 8'h03;
					F3_LW, F3_LWU: dec.byte_enable = 8'h0f;
					F3_LD: dec.byte_enable = 8'hff;
					default: dec.byte_enable = 8'h00;
				endcase
			end
			OPC_STORE: begin
				dec.rs1_r_ena = 1'b1;
				dec.rs2_r_ena = 1'b1;
				dec.op1 = rs1_data;
				dec.op2 = imm_s;
				dec.alu_op = ALU_ADD;
				dec.mem_w_ena = 1'b1;
				case (funct3)
					F3_SB: dec.byte_enable = 8'h01;
					F3_SH: dec.byte_enable = 8'h03;
					F3_SW: dec.byte_enable = 8'h0f;
					F3_SD: dec.byte_enable = 8'hff;
					default: dec.byte_enable = 8'h00;
				endcase
			end
			default: dec = '0;
		endcase
		// addresses only where the port is used
		dec.rs1_r_addr = dec.rs1_r_ena ? inst[19:15] : 5'd0;
		dec.rs2_r_addr = dec.rs2_r_ena ? inst[24:20] : 5'd0;
		dec.rd_w_addr = dec.rd_w_ena ? inst[11:7] : 5'd0;
	end

endmodule

`default_nettype wire

/* inst_queue.sv */
// instruction packet queue
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
	parameter int DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  rv_core_pkg::fetch_pkt_t push_pkt,
	input  logic                   pop,
	output rv_core_pkg::fetch_pkt_t head,
	output logic                   not_empty,
	output logic                   credit
);
	import rv_core_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = AW + 1;

	fetch_pkt_t    slots [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// wraps at DEPTH, not only at powers of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CW'(push) - CW'(pop);
			credit <= pop;   // one credit back per pop
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr] <= push_pkt;
	end

	assign head = slots[rd_ptr];
	assign not_empty = (count != '0);

endmodule

`default_nettype wire

/* regfile.sv */
// integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	output logic [63:0] rs1_data,
	output logic [63:0] rs2_data,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [63:0] wr_data
);
	logic [63:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;   // x0 never written
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* retire_stage.sv */
// issue control and retire register
`timescale 1ns/1ps
`default_nettype none

module retire_stage #(
	parameter int OUT_CREDITS = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 not_empty,
	input  logic                 out_credit,
	input  rv_core_pkg::retire_t rec,
	output logic                 issue,
	output logic                 wr_en,
	output logic [4:0]           wr_addr,
	output logic [63:0]          wr_data,
	output logic                 out_valid,
	output rv_core_pkg::retire_t out_rec
);
	localparam int CW = $clog2(OUT_CREDITS + 1);

	logic [CW-1:0] credits;

	assign issue = not_empty && (credits != '0);

	// write lands on the issue edge, next instruction reads it
	assign wr_en = issue && rec.rd_wr;
	assign wr_addr = rec.rd;
	assign wr_data = rec.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CW'(OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			credits <= credits + CW'(out_credit) - CW'(issue);   // both may hit at once
			out_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			out_rec <= rec;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* rv_core.f */
rv_core_pkg.sv
inst_queue.sv
id_stage.sv
regfile.sv
exe_stage.sv
retire_stage.sv
rv_core_top.sv
tb_clk_gen.sv
rv_core_checker.sv
rv_core_tb.sv

/* rv_core_checker.sv */
// retire record checker
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker #(
	parameter int OUT_CREDITS = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  rv_core_pkg::fetch_pkt_t in_pkt,
	input  logic                    in_credit,
	input  logic                    out_valid,
	input  rv_core_pkg::retire_t    out_rec,
	input  logic                    out_credit,
	output int                      value_errs,
	output int                      flow_errs,
	output int                      retired,
	output int                      accepted,
	output int                      credits_back
);
	import rv_core_pkg::*;

	fetch_pkt_t  sent [$];        // in-flight packets in order
	logic [63:0] model_rf [32];
	int          granted;         // downstream credits seen so far

	// expected retire record from the ISA rules
	function automatic retire_t predict(input fetch_pkt_t p);
		retire_t     e;
		logic [31:0] i;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic        alt;
		logic        cond;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] ii;
		logic [63:0] is;
		logic [63:0] ib;
		logic [63:0] iu;
		logic [63:0] ij;
		logic [63:0] sum;
		logic [31:0] w;
		logic [5:0]  sh;
		i = p.inst;
		opc = i[6:0];
		f3 = i[14:12];
		alt = i[30];
		a = model_rf[i[19:15]];
		b = model_rf[i[24:20]];
		ii = {{52{i[31]}}, i[31:20]};
		is = {{52{i[31]}}, i[31:25], i[11:7]};
		ib = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
		iu = {{32{i[31]}}, i[31:12], 12'h000};
		ij = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
		e = '0;
		e.pc = p.pc;
		e.inst = i;
		e.rd = i[11:7];
		e.next_pc = p.pc + 64'd4;
		case (opc)
			OPC_OP, OPC_OP_IMM: begin
				if (opc == OPC_OP_IMM)
					b = ii;
				sh = b[5:0];
				e.rd_wr = 1'b1;
				case (f3)
					3'b000: begin
						if (opc == OPC_OP && alt)
							e.result = a - b;
						else
							e.result = a + b;
					end
					3'b001: e.result = a << sh;
					3'b010: e.result = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					3'b011: e.result = (a < b) ? 64'd1 : 64'd0;
					3'b100: e.result = a ^ b;
					3'b101: begin
						if (alt)
							e.result = $signed(a) >>> sh;
						else
							e.result = a >> sh;
					end
					3'b110: e.result = a | b;
					default: e.result = a & b;
				endcase
			end
			OPC_OP32, OPC_OP_IMM32: begin
				if (opc == OPC_OP_IMM32)
					b = ii;
				e.rd_wr = 1'b1;
				if (f3 == 3'b000)
					w = (opc == OPC_OP32 && alt) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
				else if (f3 == 3'b001)
					w = a[31:0] << b[4:0];
				else if (alt)
					w = $signed(a[31:0]) >>> b[4:0];
				else
					w = a[31:0] >> b[4:0];
				e.result = {{32{w[31]}}, w};   // W results sign-extend
			end
			OPC_LUI: begin
				e.rd_wr = 1'b1;
				e.result = iu;
			end
			OPC_AUIPC: begin
				e.rd_wr = 1'b1;
				e.result = p.pc + iu;
			end
			OPC_BRANCH: begin
				case (f3)
					3'b000: cond = (a == b);
					3'b001: cond = (a != b);
					3'b100: cond = ($signed(a) < $signed(b));
					3'b101: cond = ($signed(a) >= $signed(b));
					3'b110: cond = (a < b);
					default: cond = (a >= b);
				endcase
				e.taken = cond;
				if (cond)
					e.next_pc = p.pc + ib;
			end
			OPC_JAL, OPC_JALR: begin
				e.rd_wr = 1'b1;
				e.result = p.pc + 64'd4;   // link
				e.taken = 1'b1;
				sum = a + ii;
				e.next_pc = (opc == OPC_JAL) ? p.pc + ij : {sum[63:1], 1'b0};
			end
			OPC_LOAD: begin
				e.mem_r_ena = 1'b1;
				e.mem_addr = a + ii;
				e.result = a + ii;
				e.mem_ext_un = f3[2];
				e.byte_enable = 8'((16'd1 << (4'd1 << f3[1:0])) - 16'd1);
			end
			OPC_STORE: begin
				e.mem_w_ena = 1'b1;
				e.mem_addr = a + is;
				e.store_data = b;
				e.byte_enable = 8'((16'd1 << (4'd1 << f3[1:0])) - 16'd1);
			end
			default: e.rd = 5'd0;   // unknown opcode does nothing
		endcase
		return e;
	endfunction

	task automatic compare_field(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic compare_record(input retire_t got, input retire_t exp);
		compare_field("pc", got.pc, exp.pc);
		compare_field("inst", 64'(got.inst), 64'(exp.inst));
		compare_field("rd_wr", 64'(got.rd_wr), 64'(exp.rd_wr));
		if (exp.rd_wr)
			compare_field("rd", 64'(got.rd), 64'(exp.rd));
		compare_field("result", got.result, exp.result);
		compare_field("taken", 64'(got.taken), 64'(exp.taken));
		compare_field("next_pc", got.next_pc, exp.next_pc);
		compare_field("mem_r_ena", 64'(got.mem_r_ena), 64'(exp.mem_r_ena));
		compare_field("mem_w_ena", 64'(got.mem_w_ena), 64'(exp.mem_w_ena));
		if (exp.mem_r_ena || exp.mem_w_ena) begin
			compare_field("mem_addr", got.mem_addr, exp.mem_addr);
			compare_field("byte_enable", 64'(got.byte_enable), 64'(exp.byte_enable));
			compare_field("mem_ext_un", 64'(got.mem_ext_un), 64'(exp.mem_ext_un));
		end
		if (exp.mem_w_ena)
			compare_field("store_data", got.store_data, exp.store_data);
	endtask

	always @(posedge clk) begin
		fetch_pkt_t pkt;
		retire_t    exp;
		if (rst) begin
			sent.delete();
			for (int r = 0; r < 32; r++)
				model_rf[r] = '0;
			granted = 0;
			retired = 0;
			accepted = 0;
			credits_back = 0;
		end else begin
			if (in_valid) begin
				sent.push_back(in_pkt);
				accepted++;
			end
			if (in_credit)
				credits_back++;
			if (credits_back > accepted) begin
				flow_errs++;
				$display("t=%0t: in_credit pulsed with no packet accepted", $time);
			end
			if (out_valid) begin
				if (retired + 1 > OUT_CREDITS + granted) begin
					flow_errs++;
					$display("t=%0t: out_valid sent without an output credit", $time);
				end
				if (sent.size() == 0) begin
					flow_errs++;
					$display("t=%0t: out_valid with no packet outstanding", $time);
				end else begin
					pkt = sent.pop_front();
					exp = predict(pkt);
					compare_record(out_rec, exp);
					if (exp.rd_wr && exp.rd != 5'd0)
						model_rf[exp.rd] = exp.result;
				end
				retired++;
			end
			if (out_credit)
				granted++;
		end
	end

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
// rv64i core slice definitions
`default_nettype none

package rv_core_pkg;

	localparam int XLEN = 64;

	localparam logic [6:0] OPC_LOAD = 7'b0000011, OPC_STORE = 7'b0100011,
		OPC_OP_IMM = 7'b0010011, OPC_OP_IMM32 = 7'b0011011,
		OPC_OP = 7'b0110011, OPC_OP32 = 7'b0111011,
		OPC_LUI = 7'b0110111, OPC_AUIPC = 7'b0010111,
		OPC_BRANCH = 7'b1100011, OPC_JAL = 7'b1101111, OPC_JALR = 7'b1100111;

	// arithmetic group, shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010,
		F3_SLTU = 3'b011, F3_XOR = 3'b100, F3_SR = 3'b101, F3_OR = 3'b110, F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000, F3_BNE = 3'b001, F3_BLT = 3'b100,
		F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111;
	localparam logic [2:0] F3_LB = 3'b000, F3_LH = 3'b001, F3_LW = 3'b010, F3_LD = 3'b011,
		F3_LBU = 3'b100, F3_LHU = 3'b101, F3_LWU = 3'b110;
	localparam logic [2:0] F3_SB = 3'b000, F3_SH = 3'b001, F3_SW = 3'b010, F3_SD = 3'b011;

	typedef enum logic [4:0] {
		ALU_ZERO, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI,
		ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
	} fetch_pkt_t;

	typedef struct packed {
		logic            rs1_r_ena;
		logic [4:0]      rs1_r_addr;
		logic            rs2_r_ena;
		logic [4:0]      rs2_r_addr;
		logic            rd_w_ena;
		logic [4:0]      rd_w_addr;
		alu_op_e         alu_op;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
		logic            branch;
		logic [XLEN-1:0] b_offset;
		logic [1:0]      jump;          // [1] jal, [0] jalr
		logic [XLEN-1:0] j_offset;
		logic            mem_r_ena;
		logic            mem_w_ena;
		logic            mem_to_reg;
		logic [7:0]      byte_enable;
		logic            mem_ext_un;
	} dec_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
		logic            rd_wr;
		logic [4:0]      rd;
		logic [XLEN-1:0] result;
		logic            taken;
		logic [XLEN-1:0] next_pc;
		logic            mem_r_ena;
		logic            mem_w_ena;
		logic [XLEN-1:0] mem_addr;
		logic [XLEN-1:0] store_data;
		logic [7:0]      byte_enable;
		logic            mem_ext_un;
	} retire_t;

endpackage

`default_nettype wire

/* rv_core_tb.sv */
// rv64i core slice testbench
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
	import rv_core_pkg::*;

	localparam int IN_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int NUM_INST = 400;
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 2000;

	logic       clk;
	logic       rst;
	logic       in_valid;
	fetch_pkt_t in_pkt;
	logic       in_credit;
	logic       out_valid;
	retire_t    out_rec;
	logic       out_credit;

	int value_errs;
	int flow_errs;
	int retired;
	int accepted;
	int credits_back;
	int in_back = 0;    // input credits regained
	int owed = 0;       // records seen downstream
	int returned = 0;   // downstream credits given back

	tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(2)) clk_i (.clk, .rst);

	rv_core_top #(.IN_DEPTH(IN_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut_i (
		.clk, .rst, .in_valid, .in_pkt, .in_credit,
		.out_valid, .out_rec, .out_credit
	);

	rv_core_checker #(.OUT_CREDITS(OUT_CREDITS)) chk_i (
		.clk, .rst, .in_valid, .in_pkt, .in_credit,
		.out_valid, .out_rec, .out_credit,
		.value_errs, .flow_errs, .retired, .accepted, .credits_back
	);

	// mostly low registers so results feed later instructions
	function automatic logic [4:0] pick_reg();
		if ($urandom_range(0, 3) == 0)
			return 5'($urandom_range(0, 31));
		return 5'($urandom_range(0, 7));
	endfunction

	function automatic logic [2:0] pick_w_funct3();
		case ($urandom_range(0, 2))
			0: return 3'b000;
			1: return 3'b001;
			default: return 3'b101;
		endcase
	endfunction

	function automatic logic [31:0] make_inst();
		logic [31:0] w;
		logic [2:0]  f3;
		logic        alt;
		int          pick;
		w = $urandom();
		w[11:7] = pick_reg();
		w[19:15] = pick_reg();
		w[24:20] = pick_reg();
		alt = 1'($urandom_range(0, 1));
		f3 = 3'($urandom_range(0, 7));
		pick = $urandom_range(0, 21);
		if (pick <= 2) begin
			w[31:25] = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, alt, 5'b0} : 7'b0;
			w[14:12] = f3;
			w[6:0] = OPC_OP;
		end else if (pick <= 5) begin
			if (f3 == 3'b001)
				w[31:26] = 6'b0;
			else if (f3 == 3'b101)
				w[31:26] = {1'b0, alt, 4'b0};   // srli or srai with 6-bit shamt
			w[14:12] = f3;
			w[6:0] = OPC_OP_IMM;
		end else if (pick <= 9) begin
			f3 = pick_w_funct3();
			if (pick <= 7 || f3 != 3'b000)
				w[31:25] = {1'b0, alt && (f3 != 3'b001), 5'b0};
			w[14:12] = f3;
			w[6:0] = (pick <= 7) ? OPC_OP32 : OPC_OP_IMM32;
		end else if (pick == 10) begin
			w[6:0] = OPC_LUI;
		end else if (pick == 11) begin
			w[6:0] = OPC_AUIPC;
		end else if (pick <= 14) begin
			f3 = 3'($urandom_range(0, 5));
			if (f3 >= 3'd2)
				f3 = f3 + 3'd2;   // skip the two unused codes
			w[14:12] = f3;
			w[6:0] = OPC_BRANCH;
		end else if (pick == 15) begin
			w[6:0] = OPC_JAL;
		end else if (pick == 16) begin
			w[14:12] = 3'b000;
			w[6:0] = OPC_JALR;
		end else if (pick <= 18) begin
			w[14:12] = 3'($urandom_range(0, 6));
			w[6:0] = OPC_LOAD;
		end else if (pick <= 20) begin
			w[14:12] = 3'($urandom_range(0, 3));
			w[6:0] = OPC_STORE;
		end else begin
			case ($urandom_range(0, 3))
				0: w[6:0] = 7'h0f;
				1: w[6:0] = 7'h73;
				2: w[6:0] = 7'h2f;
				default: w[6:0] = 7'h00;
			endcase
		end
		return w;
	endfunction

	function automatic logic [63:0] make_pc();
		logic [63:0] pc;
		pc = {$urandom(), $urandom()};
		pc[1:0] = 2'b00;
		return pc;
	endfunction

	always @(posedge clk) begin
		if (in_credit)
			in_back <= in_back + 1;
		if (out_valid)
			owed <= owed + 1;
	end

	// downstream credit return with random holds
	initial begin
		int hold;
		hold = 0;
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			if (returned < owed && hold == 0) begin
				out_credit <= 1'b1;
				returned++;
				if ($urandom_range(0, 3) == 0)
					hold = $urandom_range(1, 8);
			end else begin
				out_credit <= 1'b0;
				if (hold > 0)
					hold--;
			end
		end
	end

	initial begin
		int spent;
		int sent_n;
		int idle;
		int cyc;
		int other_errs;
		void'($urandom(32'h5716));
		in_valid = 1'b0;
		in_pkt = '0;
		spent = 0;
		sent_n = 0;
		idle = 0;
		cyc = 0;
		other_errs = 0;

		@(posedge clk);
		while (rst && cyc <= 20) begin
			@(posedge clk);
			cyc++;
		end
		if (rst) begin
			other_errs++;
			$display("reset never released");
		end

		while (other_errs == 0 && sent_n < NUM_INST && idle <= STALL_LIMIT) begin
			@(posedge clk);
			if (IN_DEPTH + in_back - spent > 0 && $urandom_range(0, 4) != 0) begin
				in_valid <= 1'b1;
				in_pkt <= '{pc: make_pc(), inst: make_inst()};
				spent++;
				sent_n++;
				idle = 0;
			end else begin
				in_valid <= 1'b0;
				idle++;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		if (idle > STALL_LIMIT) begin
			other_errs++;
			$display("no input credit came back for %0d cycles", idle);
		end

		cyc = 0;
		while (other_errs == 0 && retired < NUM_INST && cyc < DRAIN_LIMIT) begin
			@(negedge clk);
			cyc++;
		end
		if (retired != NUM_INST) begin
			other_errs++;
			$display("only %0d of %0d records retired", retired, NUM_INST);
		end
		if (credits_back != accepted) begin
			other_errs++;
			$display("%0d input credits returned for %0d packets", credits_back, accepted);
		end
		$display("errors: value %0d, flow %0d, other %0d, retired %0d",
			value_errs, flow_errs, other_errs, retired);
		if (value_errs == 0 && flow_errs == 0 && other_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_core_top.sv */
// rv64i core slice top
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
	parameter int IN_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  rv_core_pkg::fetch_pkt_t in_pkt,
	output logic                    in_credit,
	output logic                    out_valid,
	output rv_core_pkg::retire_t    out_rec,
	input  logic                    out_credit
);
	import rv_core_pkg::*;

	fetch_pkt_t      head;
	dec_t            dec;
	retire_t         rec;
	logic            not_empty;
	logic            issue;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic            wr_en;
	logic [4:0]      wr_addr;
	logic [XLEN-1:0] wr_data;

	inst_queue #(.DEPTH(IN_DEPTH)) queue_i (
		.clk, .rst,
		.push(in_valid), .push_pkt(in_pkt),
		.pop(issue), .head, .not_empty,
		.credit(in_credit)
	);

	id_stage id_i (
		.inst(head.inst), .pc(head.pc),
		.rs1_data, .rs2_data, .dec
	);

	regfile rf_i (
		.clk, .rst,
		.rs1_addr(dec.rs1_r_addr), .rs2_addr(dec.rs2_r_addr),
		.rs1_data, .rs2_data,
		.wr_en, .wr_addr, .wr_data
	);

	exe_stage exe_i (
		.pc(head.pc), .inst(head.inst), .dec,
		.rs1_data, .rs2_data, .rec
	);

	retire_stage #(.OUT_CREDITS(OUT_CREDITS)) ret_i (
		.clk, .rst, .not_empty, .out_credit, .rec,
		.issue, .wr_en, .wr_addr, .wr_data,
		.out_valid, .out_rec
	);

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;   // released on the last reset edge
	end

endmodule

`default_nettype wire
